// File: logic/engine_cfg_pkg.sv
package engine_cfg_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int data_w  = 32;
    localparam int addr_w  = 32;
    localparam int shift_w = 5;
    localparam int kind_w  = 3;
    localparam int cmd_w   = 2;

    // Record length and slot index width
    localparam int seq_len = 8;
    localparam int slot_w  = $clog2(seq_len);

    // Both FIFOs share depth and threshold
    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 8;

    // ------------------------------------------------------------
    // Buffer kinds
    // ------------------------------------------------------------
    // Only these two carry setup data
    localparam logic [kind_w-1:0] kind_cu_setup     = 3'd6;
    localparam logic [kind_w-1:0] kind_engine_setup = 3'd7;

    // ------------------------------------------------------------
    // Slot map of one configuration record
    // ------------------------------------------------------------
    localparam logic [slot_w-1:0] slot_flags  = 3'd0;
    localparam logic [slot_w-1:0] slot_start  = 3'd1;
    localparam logic [slot_w-1:0] slot_end    = 3'd2;
    localparam logic [slot_w-1:0] slot_stride = 3'd3;
    localparam logic [slot_w-1:0] slot_gran   = 3'd4;
    localparam logic [slot_w-1:0] slot_cmd    = 3'd5;
    localparam logic [slot_w-1:0] slot_size   = 3'd6;
    localparam logic [slot_w-1:0] slot_const  = 3'd7;

    // Memory response word
    typedef struct packed {
        logic [kind_w-1:0]  kind;
        logic [addr_w-1:0]  offset;
        logic [shift_w-1:0] shift;
        logic [data_w-1:0]  data;
    } response_word_t;

    // Finished configuration record
    typedef struct packed {
        logic              increment;
        logic              decrement;
        logic              mode_sequence;
        logic              mode_buffer;
        logic              mode_counter;
        logic [data_w-1:0] index_start;
        logic [data_w-1:0] index_end;
        logic [data_w-1:0] stride;
        logic [data_w-2:0] granularity;
        logic              direction;
        logic [cmd_w-1:0]  cmd;
        logic [kind_w-1:0] buffer;
        logic [data_w-1:0] array_size;
        logic [data_w-1:0] const_value;
    } cfg_record_t;

endpackage : engine_cfg_pkg

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = engine_cfg_pkg::fifo_depth
) (
    input  logic     ap_clk,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     valid,
    output logic     empty,
    output logic     full,
    output logic     prog_full
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [ptr_w-1:0] last_ptr   = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_cnt   = cnt_w'(depth);
    localparam logic [cnt_w-1:0] thresh_cnt = cnt_w'(engine_cfg_pkg::prog_thresh);

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------
    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    // Writes into a full FIFO and reads from an empty one are dropped
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == full_cnt);
    assign prog_full = (count >= thresh_cnt);

    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            // Read data shows up one cycle after the pop
            valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_fifo

// File: logic/setup_word_filter.sv
`timescale 1ns/1ps

module setup_word_filter #(
    parameter int seq_base = 0
) (
    input  logic                           ap_clk,
    input  logic                           reset,
    input  logic                           resp_valid,
    input  engine_cfg_pkg::response_word_t resp_word,
    output logic                           keep_valid,
    output engine_cfg_pkg::response_word_t keep_word
);

    // Window bounds of this engine with the upper bound exclusive
    localparam logic [engine_cfg_pkg::addr_w-1:0] win_lo =
        engine_cfg_pkg::addr_w'(seq_base);
    localparam logic [engine_cfg_pkg::addr_w-1:0] win_hi =
        engine_cfg_pkg::addr_w'(seq_base + engine_cfg_pkg::seq_len);

    logic                              word_valid;
    engine_cfg_pkg::response_word_t    word_q;
    logic [engine_cfg_pkg::addr_w-1:0] seq_index;
    logic                              kind_ok;
    logic                              in_window;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        word_q <= resp_word;
    end

    // ------------------------------------------------------------
    // Push filter
    // ------------------------------------------------------------
    assign seq_index = word_q.offset >> word_q.shift;
    assign kind_ok   = (word_q.kind == engine_cfg_pkg::kind_cu_setup) |
                       (word_q.kind == engine_cfg_pkg::kind_engine_setup);
    assign in_window = (seq_index >= win_lo) & (seq_index < win_hi);

    assign keep_valid = word_valid & kind_ok & in_window;
    assign keep_word  = word_q;

endmodule : setup_word_filter

// File: logic/cfg_record_assembler.sv
`timescale 1ns/1ps

module cfg_record_assembler #(
    parameter int seq_base = 0
) (
    input  logic                           ap_clk,
    input  logic                           reset,
    input  logic                           resp_out_valid,
    input  engine_cfg_pkg::response_word_t resp_out_word,
    input  logic                           resp_empty,
    input  logic                           rec_prog_full,
    output logic                           resp_pop,
    output logic                           rec_push,
    output engine_cfg_pkg::cfg_record_t    rec_data
);

    localparam int seq_len = engine_cfg_pkg::seq_len;
    localparam int data_w  = engine_cfg_pkg::data_w;
    localparam int cmd_w   = engine_cfg_pkg::cmd_w;
    localparam int kind_w  = engine_cfg_pkg::kind_w;

    localparam logic [engine_cfg_pkg::addr_w-1:0] base_index =
        engine_cfg_pkg::addr_w'(seq_base);

    logic [seq_len-1:0]                slot_q;
    logic [seq_len-1:0]                slot_next;
    logic [engine_cfg_pkg::slot_w-1:0] slot_idx;
    logic [engine_cfg_pkg::addr_w-1:0] word_index;
    logic                              seq_start;
    logic                              last_word;
    logic [data_w-1:0]                 word_data;

    // ------------------------------------------------------------
    // Pop control
    // ------------------------------------------------------------
    // Hold off while a record goes out or the record FIFO backs up
    assign resp_pop = ~resp_empty & ~rec_push & ~rec_prog_full;

    // ------------------------------------------------------------
    // Sequence tracker
    // ------------------------------------------------------------
    assign word_index = resp_out_word.offset >> resp_out_word.shift;
    assign word_data  = resp_out_word.data;

    // A sequence only opens at the window base
    assign seq_start = (word_index == base_index) & ~(|slot_q);
    assign slot_next = seq_start ? seq_len'(1) : (slot_q << 1);
    assign last_word = resp_out_valid & slot_next[seq_len-1];

    // Slot number of the word being accepted
    always_comb begin
        slot_idx = '0;
        for (int i = 0; i < seq_len; i++) begin
            if (slot_next[i]) begin
                slot_idx = engine_cfg_pkg::slot_w'(i);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            slot_q   <= '0;
            rec_push <= 1'b0;
        end else begin
            rec_push <= last_word;
            if (last_word) begin
                slot_q <= '0;
            end else if (resp_out_valid) begin
                slot_q <= slot_next;
            end
        end
    end

    // ------------------------------------------------------------
    // Field capture
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (resp_out_valid && (|slot_next)) begin
            case (slot_idx)
                engine_cfg_pkg::slot_flags: begin
                    rec_data.increment     <= word_data[0];
                    rec_data.decrement     <= word_data[1];
                    rec_data.mode_sequence <= word_data[2];
                    rec_data.mode_buffer   <= word_data[3];
                    rec_data.mode_counter  <= word_data[4];
                end
                engine_cfg_pkg::slot_start: begin
                    rec_data.index_start <= word_data;
                end
                engine_cfg_pkg::slot_end: begin
                    rec_data.index_end <= word_data;
                end
                engine_cfg_pkg::slot_stride: begin
                    rec_data.stride <= word_data;
                end
                engine_cfg_pkg::slot_gran: begin
                    // Top bit carries the direction
                    rec_data.granularity <= word_data[data_w-2:0];
                    rec_data.direction   <= word_data[data_w-1];
                end
                engine_cfg_pkg::slot_cmd: begin
                    rec_data.cmd    <= word_data[cmd_w-1:0];
                    rec_data.buffer <= word_data[cmd_w+kind_w-1:cmd_w];
                end
                engine_cfg_pkg::slot_size: begin
                    rec_data.array_size <= word_data;
                end
                engine_cfg_pkg::slot_const: begin
                    rec_data.const_value <= word_data;
                end
            endcase
        end
    end

endmodule : cfg_record_assembler

// File: logic/engine_config_reader.sv
`timescale 1ns/1ps

module engine_config_reader #(
    parameter int seq_base = 0
) (
    input  logic                           ap_clk,
    input  logic                           reset,
    input  logic                           resp_valid,
    input  engine_cfg_pkg::response_word_t resp_word,
    input  logic                           cfg_rd_en,
    output logic                           resp_full,
    output logic                           cfg_valid,
    output engine_cfg_pkg::cfg_record_t    cfg_record
);

    // ------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------
    logic                           keep_valid;
    engine_cfg_pkg::response_word_t keep_word;
    logic                           resp_pop;
    logic                           resp_empty;
    logic                           resp_out_valid;
    engine_cfg_pkg::response_word_t resp_out_word;
    logic                           rec_push;
    engine_cfg_pkg::cfg_record_t    rec_data;
    logic                           rec_prog_full;

    setup_word_filter #(
        .seq_base(seq_base)
    ) u_filter (
        .ap_clk    (ap_clk),
        .reset     (reset),
        .resp_valid(resp_valid),
        .resp_word (resp_word),
        .keep_valid(keep_valid),
        .keep_word (keep_word)
    );

    // Accepted setup words wait here for the assembler
    sync_fifo #(
        .payload_t(engine_cfg_pkg::response_word_t),
        .depth    (engine_cfg_pkg::fifo_depth)
    ) u_resp_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .wr_en    (keep_valid),
        .din      (keep_word),
        .rd_en    (resp_pop),
        .dout     (resp_out_word),
        .valid    (resp_out_valid),
        .empty    (resp_empty),
        .full     (resp_full),
        .prog_full()
    );

    cfg_record_assembler #(
        .seq_base(seq_base)
    ) u_assembler (
        .ap_clk        (ap_clk),
        .reset         (reset),
        .resp_out_valid(resp_out_valid),
        .resp_out_word (resp_out_word),
        .resp_empty    (resp_empty),
        .rec_prog_full (rec_prog_full),
        .resp_pop      (resp_pop),
        .rec_push      (rec_push),
        .rec_data      (rec_data)
    );

    // Finished records wait here until the engine pops them
    sync_fifo #(
        .payload_t(engine_cfg_pkg::cfg_record_t),
        .depth    (engine_cfg_pkg::fifo_depth)
    ) u_cfg_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .wr_en    (rec_push),
        .din      (rec_data),
        .rd_en    (cfg_rd_en),
        .dout     (cfg_record),
        .valid    (cfg_valid),
        .empty    (),
        .full     (),
        .prog_full(rec_prog_full)
    );

endmodule : engine_config_reader

// File: sim/engine_config_reader_asserts.sv
`timescale 1ns/1ps

module engine_config_reader_asserts (
    input logic                        ap_clk,
    input logic                        reset,
    input logic                        cfg_rd_en,
    input logic                        cfg_valid,
    input logic                        resp_full,
    input engine_cfg_pkg::cfg_record_t cfg_record
);

    int fail_count = 0;

    // ------------------------------------------------------------
    // Output protocol
    // ------------------------------------------------------------
    // Read data only follows a pop request
    property valid_after_pop;
        @(posedge ap_clk) disable iff (reset)
        cfg_valid |-> $past(cfg_rd_en);
    endproperty

    // Flags cleared by the reset edge
    property quiet_in_reset;
        @(posedge ap_clk)
        reset |=> (!cfg_valid && !resp_full);
    endproperty

    property record_known;
        @(posedge ap_clk) disable iff (reset)
        cfg_valid |-> !$isunknown(cfg_record);
    endproperty

    a_valid_after_pop: assert property (valid_after_pop) else begin
        fail_count++;
        $error("cfg_valid high without a pop request in the previous cycle");
    end

    a_quiet_in_reset: assert property (quiet_in_reset) else begin
        fail_count++;
        $error("cfg_valid or resp_full high during reset");
    end

    a_record_known: assert property (record_known) else begin
        fail_count++;
        $error("cfg_record has unknown bits while cfg_valid is high");
    end

endmodule : engine_config_reader_asserts

bind engine_config_reader engine_config_reader_asserts u_asserts (
    .ap_clk    (ap_clk),
    .reset     (reset),
    .cfg_rd_en (cfg_rd_en),
    .cfg_valid (cfg_valid),
    .resp_full (resp_full),
    .cfg_record(cfg_record)
);

// File: sim/tb_engine_config_reader.sv
`timescale 1ns/1ps

module tb_engine_config_reader;

    localparam int max_cycles = 2000;

    logic                           ap_clk;
    logic                           reset;
    logic                           resp_valid;
    engine_cfg_pkg::response_word_t resp_word;
    logic                           cfg_rd_en;
    logic                           resp_full;
    logic                           cfg_valid;
    engine_cfg_pkg::cfg_record_t    cfg_record;

    engine_cfg_pkg::cfg_record_t exp_q [$];
    engine_cfg_pkg::cfg_record_t exp_rec;
    logic [15:0]                 lfsr_state;
    int                          cycle_count;
    int                          recs_seen;
    int                          checks;
    int                          errors;
    int                          test_errors;
    int                          tests_run;

    engine_config_reader #(
        .seq_base(0)
    ) UUT (
        .ap_clk    (ap_clk),
        .reset     (reset),
        .resp_valid(resp_valid),
        .resp_word (resp_word),
        .cfg_rd_en (cfg_rd_en),
        .resp_full (resp_full),
        .cfg_valid (cfg_valid),
        .cfg_record(cfg_record)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    // Record fields straight from the slot map
    function automatic engine_cfg_pkg::cfg_record_t expect_record(input logic [31:0] w [8]);
        engine_cfg_pkg::cfg_record_t r;
        r.increment     = w[0][0];
        r.decrement     = w[0][1];
        r.mode_sequence = w[0][2];
        r.mode_buffer   = w[0][3];
        r.mode_counter  = w[0][4];
        r.index_start   = w[1];
        r.index_end     = w[2];
        r.stride        = w[3];
        r.granularity   = w[4][30:0];
        r.direction     = w[4][31];
        r.cmd           = w[5][1:0];
        r.buffer        = w[5][4:2];
        r.array_size    = w[6];
        r.const_value   = w[7];
        return r;
    endfunction

    task automatic send_word(input logic [2:0] kind, input logic [31:0] index,
                             input logic [4:0] shift, input logic [31:0] data);
        resp_valid       = 1'b1;
        resp_word.kind   = kind;
        resp_word.offset = index << shift;
        resp_word.shift  = shift;
        resp_word.data   = data;
        @(posedge ap_clk);
        #1;
        resp_valid = 1'b0;
    endtask

    // Noisy mode adds a stray index 3 up front and two rejected words after each slot
    task automatic send_record(input logic [4:0] shift, input logic noisy);
        logic [31:0] words [8];
        logic [2:0]  kind;
        for (int i = 0; i < 8; i++) begin
            words[i] = rand_word();
        end
        exp_q.push_back(expect_record(words));
        if (noisy) begin
            send_word(engine_cfg_pkg::kind_cu_setup, 32'd3, shift, rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            kind = i[0] ? engine_cfg_pkg::kind_engine_setup : engine_cfg_pkg::kind_cu_setup;
            send_word(kind, 32'(i), shift, words[i]);
            if (noisy) begin
                send_word(3'd2, 32'(i), shift, rand_word());
                send_word(engine_cfg_pkg::kind_engine_setup, 32'(i + 8), shift, rand_word());
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge ap_clk);
        #1;
    endtask

    task automatic wait_records(input int target);
        while (recs_seen < target) begin
            @(posedge ap_clk);
        end
        #1;
    endtask

    task automatic check_count(input int expected);
        checks++;
        assert (recs_seen == expected) else begin
            $display("Fail at %0t: recs_seen expected %0d, got %0d", $time, expected, recs_seen);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %0d %s: %s", tests_run, name, (errors == test_errors) ? "passed" : "failed");
        test_errors = errors;
    endtask

    // ------------------------------------------------------------
    // Output monitor sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (!reset && cfg_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("A record came out at %0t with no record expected", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_rec = exp_q.pop_front();
                assert (cfg_record === exp_rec) else begin
                    $display("Fail at %0t: cfg_record expected %h, got %h",
                             $time, exp_rec, cfg_record);
                    errors++;
                end
                recs_seen++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        resp_valid  = 1'b0;
        resp_word   = '0;
        cfg_rd_en   = 1'b0;
        lfsr_state  = 16'd88;
        recs_seen   = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        repeat (5) @(posedge ap_clk);
        #1;
        reset = 1'b0;

        checks += 2;
        assert (cfg_valid === 1'b0) else begin
            $display("Fail at %0t: cfg_valid expected 0, got %b", $time, cfg_valid);
            errors++;
        end
        assert (resp_full === 1'b0) else begin
            $display("Fail at %0t: resp_full expected 0, got %b", $time, resp_full);
            errors++;
        end
        cfg_rd_en = 1'b1;
        idle(20);
        check_count(0);
        finish_test("reset and idle");

        send_record(5'd0, 1'b0);
        wait_records(1);
        finish_test("single record");

        send_record(5'd0, 1'b1);
        wait_records(2);
        finish_test("rejected words");

        send_record(5'd3, 1'b0);
        wait_records(3);
        finish_test("shifted offsets");

        // Records pile up in the config FIFO until popped
        cfg_rd_en = 1'b0;
        repeat (3) send_record(5'd0, 1'b0);
        idle(40);
        check_count(3);
        cfg_rd_en = 1'b1;
        wait_records(6);
        idle(10);
        check_count(6);
        finish_test("back-pressure");

        errors += UUT.u_asserts.fail_count;
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_engine_config_reader

// File: tb.f
logic/engine_cfg_pkg.sv
logic/sync_fifo.sv
logic/setup_word_filter.sv
logic/cfg_record_assembler.sv
logic/engine_config_reader.sv
sim/engine_config_reader_asserts.sv
sim/tb_engine_config_reader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the engine config reader testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_engine_config_reader \
    -f tb.f --Mdir obj_dir &&
result=$(./obj_dir/Vtb_engine_config_reader) ||
{ echo "$result"; echo "Build or run failed"; exit 1; }
echo "$result"
echo "$result" | grep -q "^NO ERRORS$" && exit 0 || exit 1
